//--- peakSearchTop.f
+incdir+include
rtl/peakPkg.sv
rtl/wbPkg.sv
rtl/signedMax4.sv
rtl/peakTree.sv
rtl/sampleBank.sv
rtl/wbPeakRegs.sv
rtl/peakSearchTop.sv
testbench/peakSearchTb.sv

//--- Makefile
# Verilator build and run for the peak search testbench
VERILATOR ?= verilator
TOP ?= peakSearchTb
FILELIST ?= peakSearchTop.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= All checks passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/peakVectors.txt
// columns, all hex: mode seed position peak expectedIndex expectedValue
// mode 0 filler below peak, 1 filler 0..peak-1, 2 all equal, 3 twin at pos+1, 4 twin at 63, f ends
1 00000001 00 1ff 00 1ff
1 00000002 3f 1ff 3f 1ff
1 00000003 03 0c8 03 0c8
1 00000004 04 064 04 064
1 00000005 0f 12c 0f 12c
1 00000006 10 005 10 005
1 00000018 23 1fe 23 1fe
0 00000007 1f 1ff 1f 1ff
0 00000008 20 000 20 000
0 00000009 2f 0fa 2f 0fa
0 0000000a 30 001 30 001
0 0000000b 3f 064 3f 064
0 0000000c 00 032 00 032
0 00000019 0b 0aa 0b 0aa
0 0000001a 1c 17f 1c 17f
// all negative frames
0 0000000d 3f 3ff 3f 3ff
0 0000000e 00 380 00 380
0 0000000f 13 2d4 13 2d4
0 00000010 2c 201 2c 201
0 0000001b 24 3f0 24 3f0
// every sample equal, lowest index wins
2 00000011 2a 07b 00 07b
2 00000012 15 3f6 00 3f6
2 00000013 00 200 00 200
// two equal peaks, lower position wins
3 00000014 07 100 07 100
3 00000015 1a 3c0 1a 3c0
4 00000016 05 150 05 150
4 00000017 00 3e8 00 3e8
4 0000001c 33 0c3 33 0c3
f 00000000 00 000 00 000

//--- include/peakTbTasks.svh
`ifndef PEAK_TB_TASKS_SVH
`define PEAK_TB_TASKS_SVH

// one step of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] state);
   logic [31:0] x;
   x = state;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

// waits for the ack of the request now on the bus
task automatic waitAck();
   int n;
   n = 0;
   accessCount++;
   do
   begin
      @(posedge clk);
      #1;                                  // sample after the edge settles
      n++;
   end
   while (!wbOut.ack && n < ackLimit);
   assert (wbOut.ack)
   else
   begin
      $display("no ack from the DUT for address %0d", wbIn.adr);
      errors++;
   end
endtask

task automatic wbWrite(input logic [6:0] adr, input logic [31:0] dat);
   wbIn.cyc = 1'b1;
   wbIn.stb = 1'b1;
   wbIn.we = 1'b1;
   wbIn.adr = adr;
   wbIn.dat = dat;
   waitAck();
   wbIn = '0;                              // drop stb once ack is seen
endtask

task automatic wbRead(input logic [6:0] adr, output logic [31:0] dat);
   wbIn.cyc = 1'b1;
   wbIn.stb = 1'b1;
   wbIn.we = 1'b0;
   wbIn.adr = adr;
   wbIn.dat = '0;
   waitAck();
   dat = wbOut.dat;                        // valid while ack is high
   wbIn = '0;
endtask

// polls status until done is set and no frame is left in flight
task automatic pollDone();
   logic [31:0] status;
   int n;
   n = 0;
   status = '0;
   while (status[1:0] != 2'b01 && n < pollLimit)
   begin
      wbRead(wbPkg::statusAddr, status);
      n++;
   end
   assert (status[1:0] == 2'b01)
   else
   begin
      $display("search never finished, last status %h", status);
      errors++;
   end
endtask

`endif

//--- testbench/peakSearchTb.sv
`timescale 1ns/1ps

module peakSearchTb;

   localparam int maxFrames = 40;
   localparam int resetCycles = 10;
   localparam int cycleLimit = maxFrames * (66 * 2 + 40) + resetCycles;
   localparam int ackLimit = 4;
   localparam int pollLimit = 16;
   localparam int colCount = 6;            // words per vector line
   localparam logic [31:0] baseSeed = 32'hea11_ec1e;

   logic clk;
   logic reset;
   wbPkg::wbReq_t wbIn;
   wbPkg::wbRsp_t wbOut;
   logic [31:0] vectors [maxFrames*colCount];
   int cycles;
   int errors;
   int checks;
   int tests;
   int accessCount;
   int ackCount;

   peakSearchTop DUT
   (
      .clk   (clk),
      .reset (reset),
      .wbIn  (wbIn),
      .wbOut (wbOut)
   );

   `include "peakTbTasks.svh"

   always #5 clk = ~clk;

   // ack monitor and run limit
   always @(posedge clk)
   begin
      cycles++;
      if (wbOut.ack)
         ackCount++;
      if (cycles > cycleLimit)
      begin
         $display("timeout, the run did not end within %0d cycles", cycleLimit);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic checkWord(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic endTest(input string name, input int errBefore);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == errBefore) ? "ok" : "FAILED");
   endtask

   // mode 0 filler below peak, 1 filler in 0..peak-1, 2 all equal,
   // 3 second peak at pos+1, 4 second peak at 63
   task automatic fillFrame(input logic [3:0] mode, input logic [31:0] seed,
                            input int pos, input logic signed [9:0] peak);
      logic [31:0] state;
      int low;
      int span;
      int value;
      state = baseSeed ^ seed;
      low = (mode == 4'd1) ? 0 : -512;
      span = int'(peak) - low;
      for (int i = 0; i < 64; i++)
      begin
         state = xorshift32(state);
         if (mode == 4'd2)
            value = int'(peak);
         else
            value = low + int'(state % 32'(span));     // clipped below peak
         if (i == pos || (mode == 4'd3 && i == pos + 1) || (mode == 4'd4 && i == 63))
            value = int'(peak);
         wbWrite(7'(i), 32'(value));
      end
   endtask

   task automatic searchAndCheck(input logic [31:0] expResult);
      logic [31:0] word;
      wbWrite(wbPkg::ctrlAddr, 32'h1);
      pollDone();
      wbRead(wbPkg::resultAddr, word);
      checkWord("result", word, expResult);
   endtask

   initial
   begin
      logic [31:0] word;
      logic [31:0] expResult;
      int k;
      int errBefore;
      int accBefore;
      int ackBefore;
      clk = 1'b0;
      reset = 1'b1;
      wbIn = '0;
      expResult = '0;
      $readmemh("testbench/peakVectors.txt", vectors);
      repeat (resetCycles) @(posedge clk);
      #1;
      reset = 1'b0;

      errBefore = errors;
      wbRead(wbPkg::statusAddr, word);
      checkWord("status", word, 32'h0);
      endTest("status after reset", errBefore);

      k = 0;
      while (k < maxFrames && vectors[k*colCount][3:0] != 4'hf)
      begin
         errBefore = errors;
         fillFrame(vectors[k*colCount][3:0], vectors[k*colCount+1],
                   int'(vectors[k*colCount+2][5:0]), vectors[k*colCount+3][9:0]);
         expResult = {16'h0, vectors[k*colCount+4][5:0], vectors[k*colCount+5][9:0]};
         searchAndCheck(expResult);
         endTest($sformatf("vector %0d", k), errBefore);
         k++;
      end

      // bank still holds the last vector frame
      errBefore = errors;
      wbWrite(wbPkg::ctrlAddr, 32'h1);
      pollDone();
      wbRead(wbPkg::statusAddr, word);
      checkWord("status", word, 32'h1);
      wbRead(wbPkg::resultAddr, word);
      checkWord("result", word, expResult);
      wbRead(wbPkg::statusAddr, word);
      checkWord("status", word, 32'h0);
      endTest("done handshake", errBefore);

      errBefore = errors;
      fillFrame(4'd1, 32'h0000_5a5a, 20, 10'sd450);
      wbWrite(wbPkg::ctrlAddr, 32'h1);
      wbWrite(7'd20, 32'h0);               // lands after the snapshot
      pollDone();
      wbRead(wbPkg::resultAddr, word);
      checkWord("result", word, {16'h0, 6'd20, 10'd450});
      endTest("snapshot at launch", errBefore);

      // frame 1 peaks at 10, frame 2 at 50, both in flight together
      errBefore = errors;
      fillFrame(4'd1, 32'h0000_c0de, 10, 10'sd300);
      wbWrite(wbPkg::ctrlAddr, 32'h1);
      wbWrite(7'd50, 32'd400);
      wbWrite(wbPkg::ctrlAddr, 32'h1);
      wbRead(wbPkg::statusAddr, word);     // first peak in, second in flight
      checkWord("status", word, 32'h3);
      pollDone();
      wbRead(wbPkg::resultAddr, word);
      checkWord("result", word, {16'h0, 6'd50, 10'd400});
      wbRead(wbPkg::statusAddr, word);
      checkWord("status", word, 32'h0);
      endTest("back to back starts", errBefore);

      errBefore = errors;
      @(posedge clk);
      #1;
      accBefore = accessCount;
      ackBefore = ackCount;
      wbWrite(7'd90, 32'h0000_0001);      // must not start a search
      wbRead(7'd90, word);
      checkWord("unmapped 90", word, 32'h0);
      wbRead(7'd67, word);
      checkWord("unmapped 67", word, 32'h0);
      wbRead(7'd127, word);
      checkWord("unmapped 127", word, 32'h0);
      wbRead(wbPkg::ctrlAddr, word);
      checkWord("ctrl", word, 32'h0);
      wbRead(wbPkg::statusAddr, word);
      checkWord("status", word, 32'h0);
      @(posedge clk);
      #1;
      checkWord("ack count", 32'(ackCount - ackBefore), 32'(accessCount - accBefore));
      endTest("unmapped and ack count", errBefore);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

//--- rtl/peakSearchTop.sv
`timescale 1ns/1ps

module peakSearchTop
(
   input  logic clk,
   input  logic reset,
   input  wbPkg::wbReq_t wbIn,
   output wbPkg::wbRsp_t wbOut
);

   logic sampleWe;
   logic [peakPkg::indexWidth-1:0] sampleAdr;
   logic [peakPkg::sampleWidth-1:0] sampleData;
   logic launch;
   logic frameValid;
   peakPkg::candidate_t [peakPkg::numSamples-1:0] frame;
   logic peakValid;
   peakPkg::candidate_t peak;

   wbPeakRegs regs
   (
      .clk        (clk),
      .reset      (reset),
      .wbIn       (wbIn),
      .wbOut      (wbOut),
      .sampleWe   (sampleWe),
      .sampleAdr  (sampleAdr),
      .sampleData (sampleData),
      .launch     (launch),
      .peakValid  (peakValid),
      .peak       (peak)
   );

   sampleBank bank
   (
      .clk        (clk),
      .reset      (reset),
      .sampleWe   (sampleWe),
      .sampleAdr  (sampleAdr),
      .sampleData (sampleData),
      .launch     (launch),
      .frameValid (frameValid),
      .frame      (frame)
   );

   peakTree tree
   (
      .clk        (clk),
      .reset      (reset),
      .frameValid (frameValid),
      .frame      (frame),
      .peakValid  (peakValid),
      .peak       (peak)
   );

endmodule

//--- rtl/wbPeakRegs.sv
`timescale 1ns/1ps

module wbPeakRegs
(
   input  logic clk,
   input  logic reset,
   input  wbPkg::wbReq_t wbIn,
   output wbPkg::wbRsp_t wbOut,
   output logic sampleWe,
   output logic [peakPkg::indexWidth-1:0] sampleAdr,
   output logic [peakPkg::sampleWidth-1:0] sampleData,
   output logic launch,
   input  logic peakValid,
   input  peakPkg::candidate_t peak
);

   logic ack;
   logic reqSeen;
   logic wrAccess;
   logic rdAccess;
   logic [wbPkg::adrWidth-1:0] sampleOff;
   logic isSample;
   logic [1:0] inFlight;                   // frames between launch and peak
   logic busy;
   logic done;
   peakPkg::candidate_t result;
   wbPkg::readWord_u readMux;
   wbPkg::readWord_u readWord;

   assign reqSeen = wbIn.cyc && wbIn.stb && !ack;
   assign wrAccess = reqSeen && wbIn.we;
   assign rdAccess = reqSeen && !wbIn.we;

   assign sampleOff = wbIn.adr - wbPkg::sampleBase;
   assign isSample = (sampleOff < wbPkg::adrWidth'(peakPkg::numSamples));

   // sample write lands at the ack edge
   assign sampleWe = wrAccess && isSample;
   assign sampleAdr = sampleOff[peakPkg::indexWidth-1:0];
   assign sampleData = wbIn.dat[peakPkg::sampleWidth-1:0];

   assign busy = (inFlight != 2'd0);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack <= 1'b0;
         launch <= 1'b0;
         readWord <= '0;
      end
      else
      begin
         ack <= reqSeen;
         launch <= wrAccess && (wbIn.adr == wbPkg::ctrlAddr) && wbIn.dat[0];
         readWord <= rdAccess ? readMux : '0;   // zero outside ack
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         inFlight <= 2'd0;
      else if (launch && !peakValid)
         inFlight <= inFlight + 2'd1;
      else if (!launch && peakValid)
         inFlight <= inFlight - 2'd1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         done <= 1'b0;
      else if (peakValid)
         done <= 1'b1;                     // new result wins over a clear
      else if (rdAccess && (wbIn.adr == wbPkg::resultAddr))
         done <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (peakValid)
         result <= peak;                   // most recent frame
   end

   always_comb
   begin
      readMux = '0;
      if (wbIn.adr == wbPkg::statusAddr)
      begin
         readMux.status.busy = busy;
         readMux.status.done = done;
      end
      else if (wbIn.adr == wbPkg::resultAddr)
      begin
         readMux.result.index = result.index;
         readMux.result.value = result.value;
      end
   end

   assign wbOut.ack = ack;
   assign wbOut.dat = readWord;

   assert property (@(posedge clk) disable iff (reset) ack |=> !ack);

   assert property (@(posedge clk) disable iff (reset)
      ack |-> $past(wbIn.cyc && wbIn.stb));

endmodule

//--- rtl/sampleBank.sv
`timescale 1ns/1ps

module sampleBank
(
   input  logic clk,
   input  logic reset,
   input  logic sampleWe,
   input  logic [peakPkg::indexWidth-1:0] sampleAdr,
   input  logic [peakPkg::sampleWidth-1:0] sampleData,
   input  logic launch,
   output logic frameValid,
   output peakPkg::candidate_t [peakPkg::numSamples-1:0] frame
);

   logic signed [peakPkg::sampleWidth-1:0] samples [peakPkg::numSamples];

   // host side register file
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < peakPkg::numSamples; i++)
            samples[i] <= '0;
      end
      else if (sampleWe)
      begin
         samples[sampleAdr] <= sampleData;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         frameValid <= 1'b0;
      else
         frameValid <= launch;             // one cycle per start
   end

   // snapshot, later sample writes leave the frame alone
   always_ff @(posedge clk)
   begin
      if (launch)
      begin
         for (int i = 0; i < peakPkg::numSamples; i++)
         begin
            frame[i].value <= samples[i];
            frame[i].index <= peakPkg::indexWidth'(i);
         end
      end
   end

endmodule

//--- rtl/peakTree.sv
`timescale 1ns/1ps

module peakTree
(
   input  logic clk,
   input  logic reset,
   input  logic frameValid,
   input  peakPkg::candidate_t [peakPkg::numSamples-1:0] frame,
   output logic peakValid,
   output peakPkg::candidate_t peak
);

   peakPkg::candidate_t [15:0] leafWin;
   logic [15:0] leafValid;
   peakPkg::candidate_t [3:0] midWin;
   logic [3:0] midValid;

   // level 1, four samples per leaf
   for (genvar i = 0; i < 16; i++)
   begin : gLeaf
      signedMax4 leaf
      (
         .clk      (clk),
         .reset    (reset),
         .inValid  (frameValid),
         .cand     (frame[4*i +: 4]),
         .outValid (leafValid[i]),
         .winner   (leafWin[i])
      );
   end

   // level 2
   for (genvar j = 0; j < 4; j++)
   begin : gMid
      signedMax4 mid
      (
         .clk      (clk),
         .reset    (reset),
         .inValid  (leafValid[4*j]),       // all leaves share timing
         .cand     (leafWin[4*j +: 4]),
         .outValid (midValid[j]),
         .winner   (midWin[j])
      );
   end

   // level 3
   signedMax4 root
   (
      .clk      (clk),
      .reset    (reset),
      .inValid  (midValid[0]),
      .cand     (midWin),
      .outValid (peakValid),
      .winner   (peak)
   );

   assert property (@(posedge clk) disable iff (reset)
      ((&leafValid) || !(|leafValid)) && ((&midValid) || !(|midValid)));

   // fixed pipeline depth, one register per level
   assert property (@(posedge clk) disable iff (reset)
      frameValid |-> ##(peakPkg::treeLevels) peakValid);

endmodule

//--- rtl/signedMax4.sv
`timescale 1ns/1ps

module signedMax4
(
   input  logic clk,
   input  logic reset,
   input  logic inValid,
   input  peakPkg::candidate_t [3:0] cand,
   output logic outValid,
   output peakPkg::candidate_t winner
);

   peakPkg::candidate_t pairLow;
   peakPkg::candidate_t pairHigh;
   peakPkg::candidate_t best;

   // returns 1 when b beats a
   function automatic logic bWins(peakPkg::candidate_t a, peakPkg::candidate_t b);
      logic aNeg;
      logic bNeg;
      aNeg = a.value[peakPkg::sampleWidth-1];
      bNeg = b.value[peakPkg::sampleWidth-1];
      case ({aNeg, bNeg})
         2'b01: bWins = 1'b0;              // a positive, b negative
         2'b10: bWins = 1'b1;              // a negative, b positive
         default:
         begin
            // same sign, so the raw bits order like the values
            if (a.value == b.value)
               bWins = (b.index < a.index);     // tie to lower index
            else
               bWins = ($unsigned(b.value) > $unsigned(a.value));
         end
      endcase
   endfunction

   always_comb
   begin
      pairLow = bWins(cand[0], cand[1]) ? cand[1] : cand[0];
      pairHigh = bWins(cand[2], cand[3]) ? cand[3] : cand[2];
      best = bWins(pairLow, pairHigh) ? pairHigh : pairLow;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         outValid <= 1'b0;
      else
         outValid <= inValid;
   end

   always_ff @(posedge clk)
   begin
      winner <= best;                      // payload only
   end

   // the registered winner dominates every input it was chosen from
   for (genvar i = 0; i < 4; i++)
   begin : gDominates
      assert property (@(posedge clk) disable iff (reset)
         outValid |-> $signed(winner.value) >= $signed($past(cand[i].value)));

      // equal values resolve to the lower index
      assert property (@(posedge clk) disable iff (reset)
         outValid && (winner.value == $past(cand[i].value))
            |-> winner.index <= $past(cand[i].index));
   end

endmodule

//--- rtl/wbPkg.sv
package wbPkg;

   localparam int adrWidth = 7;            // word address
   localparam int dataWidth = 32;

   // master to slave
   typedef struct packed
   {
      logic cyc;
      logic stb;
      logic we;
      logic [adrWidth-1:0] adr;
      logic [dataWidth-1:0] dat;
   } wbReq_t;

   // slave to master
   typedef struct packed
   {
      logic ack;
      logic [dataWidth-1:0] dat;
   } wbRsp_t;

   // register map
   localparam logic [adrWidth-1:0] sampleBase = 7'd0;    // 64 sample words
   localparam logic [adrWidth-1:0] ctrlAddr = 7'd64;     // bit 0 start, write only
   localparam logic [adrWidth-1:0] statusAddr = 7'd65;
   localparam logic [adrWidth-1:0] resultAddr = 7'd66;

   typedef struct packed
   {
      logic [dataWidth-3:0] pad;
      logic busy;
      logic done;
   } statusWord_t;

   typedef struct packed
   {
      logic [dataWidth-peakPkg::indexWidth-peakPkg::sampleWidth-1:0] pad;
      logic [peakPkg::indexWidth-1:0] index;
      logic signed [peakPkg::sampleWidth-1:0] value;
   } resultWord_t;

   // the read word means a different layout at each readable address
   typedef union packed
   {
      statusWord_t status;
      resultWord_t result;
   } readWord_u;

endpackage

//--- rtl/peakPkg.sv
package peakPkg;

   // sample format and frame geometry
   localparam int sampleWidth = 10;        // two's complement
   localparam int numSamples = 64;         // candidates per frame
   localparam int indexWidth = 6;          // log2(numSamples)

   // three 4:1 levels cover 64 inputs, one register each
   localparam int treeLevels = 3;

   // one search candidate, its value travels with its position
   typedef struct packed
   {
      logic signed [sampleWidth-1:0] value;
      logic [indexWidth-1:0] index;
   } candidate_t;

endpackage
